//--- Makefile
VERILATOR ?= verilator
TOP       ?= miss_handler_tb
FILELIST  ?= miss_handler.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= === PASS ===

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qxF '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)

//--- dv/mem_model.sv
module mem_model #(
  parameter logic [31:0] seed = 32'd65397
) (
  input  logic               clock,
  input  logic               reset,
  input  mshr_pkg::mem_cmd_t mem_cmd,
  input  mshr_pkg::addr_t    mem_addr,
  output mshr_pkg::mem_tag_t mem_response,
  output mshr_pkg::mem_tag_t mem_tag,
  output mshr_pkg::data_t    mem_rdata
);
  import mshr_pkg::*;

  logic [31:0] rng;
  // outstanding loads by tag, tag zero never used
  logic [15:0] busy;
  int          delay [16];
  addr_t       load_addr [16];
  mem_tag_t    last_grant;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  always @(posedge clock) begin : respond
    mem_tag_t pick;
    mem_tag_t cand;
    int       t;
    if (reset) begin
      rng = seed;
      busy = '0;
      last_grant = '0;
      mem_response <= '0;
      mem_tag <= '0;
      mem_rdata <= '0;
    end else begin
      // data presented last cycle was taken at this edge
      if (mem_tag != '0) busy[mem_tag] = 1'b0;
      if (mem_cmd != bus_none && mem_response != '0) begin
        last_grant = mem_response;
        rng = lcg_step(rng);
        if (mem_cmd == bus_load) begin
          busy[mem_response] = 1'b1;
          delay[mem_response] = 1 + int'(rng[18:16]) % 6;
          load_addr[mem_response] = mem_addr;
        end
      end
      // one finished load per cycle, the rest keep counting
      pick = '0;
      for (int k = 1; k < 16; k++) begin
        if (busy[k] && delay[k] == 0 && pick == '0) pick = mem_tag_t'(k);
        else if (busy[k] && delay[k] > 0) delay[k] = delay[k] - 1;
      end
      // offer the next free tag on about half the cycles
      rng = lcg_step(rng);
      cand = '0;
      for (int k = 1; k <= 15; k++) begin
        t = (int'(last_grant) + k - 1) % 15 + 1;
        if (cand == '0 && !busy[t] && rng[20]) cand = mem_tag_t'(t);
      end
      mem_response <= cand;
      mem_tag <= pick;
      mem_rdata <= (pick == '0) ? '0 : {load_addr[pick], ~load_addr[pick]};
    end
  end

endmodule

//--- dv/miss_handler_assert.sv
module miss_handler_assert #(
  parameter int depth = 8
) (
  input logic                            clock,
  input logic                            reset,
  input logic                            miss_ready,
  input mshr_pkg::mem_cmd_t              mem_cmd,
  input logic                            fill_valid,
  input logic                            fill_ready,
  input mshr_pkg::addr_t                 fill_addr,
  input mshr_pkg::data_t                 fill_data,
  input logic [$clog2(depth)-1:0]        tail_ptr
);
  import mshr_pkg::*;

  int failures = 0;

  // a stalled fill holds its address and line
  fill_held: assert property (@(posedge clock) disable iff (reset)
    fill_valid && !fill_ready |=> fill_valid && $stable(fill_addr) && $stable(fill_data))
    else begin
      failures++;
      $error("fill outputs changed while stalled");
    end

  reset_idle: assert property (@(posedge clock) reset |=> mem_cmd == bus_none)
    else begin
      failures++;
      $error("memory request active right after reset");
    end

  // tail moves only on allocation
  no_accept_stalled: assert property (@(posedge clock) disable iff (reset)
    !miss_ready |=> $stable(tail_ptr))
    else begin
      failures++;
      $error("miss accepted while miss_ready was low");
    end

endmodule

bind miss_handler miss_handler_assert #(.depth(depth)) assert0 (
  .clock      (clock),
  .reset      (reset),
  .miss_ready (miss_ready),
  .mem_cmd    (mem_cmd),
  .fill_valid (fill_valid),
  .fill_ready (fill_ready),
  .fill_addr  (fill_addr),
  .fill_data  (fill_data),
  .tail_ptr   (queue0.tail_ptr)
);

//--- dv/miss_handler_tb.sv
module miss_handler_tb;
  import mshr_pkg::*;

  localparam int depth = 8;
  localparam int reset_cycles = 3;
  localparam int total_misses = 240;

  logic                      clock;
  logic                      reset;
  logic [miss_lanes-1:0]     miss_valid;
  addr_t [miss_lanes-1:0]    miss_addr;
  mem_cmd_t [miss_lanes-1:0] miss_cmd;
  data_t [miss_lanes-1:0]    miss_data;
  logic                      miss_ready;
  mem_cmd_t                  mem_cmd;
  addr_t                     mem_addr;
  data_t                     mem_data;
  mem_tag_t                  mem_response;
  mem_tag_t                  mem_tag;
  data_t                     mem_rdata;
  logic                      fill_valid;
  addr_t                     fill_addr;
  data_t                     fill_data;
  logic                      fill_ready;
  addr_t                     lookup_addr;
  logic                      lookup_hit;
  data_t                     lookup_data;
  logic                      merge_valid;
  addr_t                     merge_addr;
  data_t                     merge_data;
  logic                      merge_hit;

  // model queue of valid entries, oldest first
  addr_t    mq_addr [$];
  mem_cmd_t mq_cmd [$];
  data_t    mq_data [$];
  bit       mq_sent [$];
  mem_tag_t mq_tag [$];
  bit       mq_back [$];

  logic [31:0] rng = 32'd65397;
  // how often the stimulus reached each corner case
  int          lookup_hits = 0;
  int          merge_hits = 0;
  int          stalled_fills = 0;
  int          stalled_offers = 0;
  int          out_of_order = 0;

  miss_handler #(.depth(depth)) dut0 (.*);

  mem_model #(.seed(32'd65397)) mem0 (.*);

  initial clock = 1'b0;
  always #5 clock = ~clock;

  function automatic logic [31:0] lcg_draw();
    rng = rng * 32'd1103515245 + 32'd12345;
    return rng;
  endfunction

  // small pool so searches and merges find matches
  function automatic addr_t pick_addr(input logic [31:0] r);
    return 32'h0000_0400 + 32'(r[26:24]);
  endfunction

  // line that memory returns for a load
  function automatic data_t expected_fill(input addr_t addr);
    return {addr, ~addr};
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("[ERROR] %0t %s got %0h expected %0h", $time, name, got, exp));
    end
  endtask

  task automatic drop_oldest();
    void'(mq_addr.pop_front());
    void'(mq_cmd.pop_front());
    void'(mq_data.pop_front());
    void'(mq_sent.pop_front());
    void'(mq_tag.pop_front());
    void'(mq_back.pop_front());
  endtask

  // outputs are read before this edge takes effect
  always @(posedge clock) begin : check_outputs
    int fu;
    int young;
    int mi;
    int ret;
    bit accept;
    bit store_retires;
    bit older_pending;
    if (dut0.assert0.failures != 0) stop_run("a bound assertion on the DUT failed");
    if (reset) begin
      mq_addr.delete();
      mq_cmd.delete();
      mq_data.delete();
      mq_sent.delete();
      mq_tag.delete();
      mq_back.delete();
    end else begin
      young = -1;
      fu = -1;
      mi = -1;
      accept = (mem_cmd != bus_none) && (mem_response != '0);
      for (int i = 0; i < mq_addr.size(); i++) begin
        if (mq_cmd[i] == bus_store && mq_addr[i] == lookup_addr) young = i;
        if (!mq_sent[i] && fu < 0) fu = i;
      end
      compare_value("lookup_hit", 64'(lookup_hit), 64'(young >= 0));
      if (young >= 0) compare_value("lookup_data", lookup_data, mq_data[young]);
      // a store sent at this edge is no longer a merge target
      for (int i = 0; i < mq_addr.size(); i++) begin
        if (mq_cmd[i] == bus_store && !mq_sent[i] && mq_addr[i] == merge_addr
            && !(accept && i == fu)) mi = i;
      end
      compare_value("merge_hit", 64'(merge_hit), 64'(mi >= 0));
      compare_value("mem_cmd", 64'(mem_cmd), (fu >= 0) ? 64'(mq_cmd[fu]) : 64'(bus_none));
      if (fu >= 0) begin
        compare_value("mem_addr", 64'(mem_addr), 64'(mq_addr[fu]));
        if (mq_cmd[fu] == bus_store) compare_value("mem_data", mem_data, mq_data[fu]);
      end
      compare_value("miss_ready", 64'(miss_ready), 64'(mq_addr.size() + miss_lanes <= depth));
      if (fill_valid) begin
        if (mq_addr.size() == 0) stop_run("fill offered with no entry pending");
        compare_value("fill entry command", 64'(mq_cmd[0]), 64'(bus_load));
        compare_value("fill_valid before load data", 64'(fill_valid), 64'(mq_back[0]));
        compare_value("fill_addr", 64'(fill_addr), 64'(mq_addr[0]));
        compare_value("fill_data", fill_data, expected_fill(mq_addr[0]));
      end
      if (young >= 0) lookup_hits++;
      if (merge_valid && mi >= 0) merge_hits++;
      if (fill_valid && !fill_ready) stalled_fills++;
      if (!miss_ready && miss_valid != '0) stalled_offers++;
      // model update for this edge
      store_retires = (mq_addr.size() > 0) && (mq_cmd[0] == bus_store) && mq_sent[0];
      if (merge_valid && mi >= 0) mq_data[mi] = merge_data;
      if (accept) begin
        mq_sent[fu] = 1'b1;
        mq_tag[fu] = mem_response;
      end
      // load data taken at this edge, maybe ahead of older loads
      if (mem_tag != '0) begin
        ret = -1;
        older_pending = 1'b0;
        for (int i = 0; i < mq_addr.size(); i++) begin
          if (mq_cmd[i] == bus_load && mq_sent[i] && !mq_back[i]) begin
            if (mq_tag[i] == mem_tag && ret < 0) ret = i;
            else if (ret < 0) older_pending = 1'b1;
          end
        end
        if (ret >= 0) begin
          mq_back[ret] = 1'b1;
          if (older_pending) out_of_order++;
        end
      end
      if (store_retires || (fill_valid && fill_ready)) begin
        drop_oldest();
      end
      if (miss_ready && miss_valid != '0) begin
        for (int l = 0; l < miss_lanes; l++) begin
          if (miss_valid[l]) begin
            mq_addr.push_back(miss_addr[l]);
            mq_cmd.push_back(miss_cmd[l]);
            mq_data.push_back(miss_data[l]);
            mq_sent.push_back(1'b0);
            mq_tag.push_back('0);
            mq_back.push_back(1'b0);
          end
        end
      end
    end
  end

  initial begin : stimulus
    logic [31:0]           r;
    logic [miss_lanes-1:0] lane_valid;
    int                    sent_lanes;
    int                    stretch;
    sent_lanes = 0;
    stretch = 0;
    reset = 1'b1;
    miss_valid = '0;
    for (int l = 0; l < miss_lanes; l++) begin
      miss_addr[l] = '0;
      miss_cmd[l] = bus_load;
      miss_data[l] = '0;
    end
    fill_ready = 1'b1;
    lookup_addr = '0;
    merge_valid = 1'b0;
    merge_addr = '0;
    merge_data = '0;
    repeat (reset_cycles) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    compare_value("miss_ready after reset", 64'(miss_ready), 64'(1));
    compare_value("fill_valid after reset", 64'(fill_valid), 64'(0));
    compare_value("mem_cmd after reset", 64'(mem_cmd), 64'(bus_none));
    while (sent_lanes < total_misses) begin
      @(posedge clock);
      if (miss_ready && miss_valid != '0) sent_lanes += $countones(miss_valid);
      // an offer stays on the lanes until it is taken
      if (miss_valid == '0 || miss_ready) begin
        for (int l = 0; l < miss_lanes; l++) begin
          r = lcg_draw();
          lane_valid[l] = r[16] && (sent_lanes < total_misses);
          miss_addr[l] <= pick_addr(r);
          miss_cmd[l] <= r[20] ? bus_store : bus_load;
          miss_data[l] <= {lcg_draw(), lcg_draw()};
        end
        miss_valid <= lane_valid;
      end
      r = lcg_draw();
      lookup_addr <= pick_addr(r);
      r = lcg_draw();
      merge_valid <= r[17] & r[18];
      merge_addr <= pick_addr(r);
      merge_data <= {lcg_draw(), lcg_draw()};
      // back-pressure in stretches of 1 to 8 cycles
      if (stretch == 0) begin
        r = lcg_draw();
        fill_ready <= r[16] | r[17];
        stretch = 1 + int'(r[21:19]);
      end else begin
        stretch--;
      end
    end
    fill_ready <= 1'b1;
    merge_valid <= 1'b0;
    do @(negedge clock); while (mq_addr.size() != 0);
    repeat (2) @(negedge clock);
    if (lookup_hits > 0 && merge_hits > 0 && stalled_fills > 0 && stalled_offers > 0
        && out_of_order > 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      stop_run("corner case never reached: search hit, merge, stalls or out-of-order return");
    end
  end

  initial begin : watchdog
    repeat (reset_cycles + 200 * (total_misses + miss_lanes)) @(posedge clock);
    stop_run("watchdog expired before the queue drained");
  end

endmodule

//--- miss_handler.f
source/mshr_pkg.sv
source/mshr_alloc_select.sv
source/mshr_lookup.sv
source/mshr_queue.sv
source/miss_handler.sv
dv/mem_model.sv
dv/miss_handler_assert.sv
dv/miss_handler_tb.sv

//--- source/miss_handler.sv
module miss_handler #(
  parameter int depth = 8
) (
  input  logic                                          clock,
  input  logic                                          reset,
  input  logic [mshr_pkg::miss_lanes-1:0]               miss_valid,
  input  mshr_pkg::addr_t [mshr_pkg::miss_lanes-1:0]    miss_addr,
  input  mshr_pkg::mem_cmd_t [mshr_pkg::miss_lanes-1:0] miss_cmd,
  input  mshr_pkg::data_t [mshr_pkg::miss_lanes-1:0]    miss_data,
  output logic                                          miss_ready,
  output mshr_pkg::mem_cmd_t                            mem_cmd,
  output mshr_pkg::addr_t                               mem_addr,
  output mshr_pkg::data_t                               mem_data,
  input  mshr_pkg::mem_tag_t                            mem_response,
  input  mshr_pkg::mem_tag_t                            mem_tag,
  input  mshr_pkg::data_t                               mem_rdata,
  output logic                                          fill_valid,
  output mshr_pkg::addr_t                               fill_addr,
  output mshr_pkg::data_t                               fill_data,
  input  logic                                          fill_ready,
  input  mshr_pkg::addr_t                               lookup_addr,
  output logic                                          lookup_hit,
  output mshr_pkg::data_t                               lookup_data,
  input  logic                                          merge_valid,
  input  mshr_pkg::addr_t                               merge_addr,
  input  mshr_pkg::data_t                               merge_data,
  output logic                                          merge_hit
);
  import mshr_pkg::*;

  // lane to slot mapping
  logic [miss_lanes-1:0][1:0] slot_lane;
  logic [1:0]                 alloc_count;

  // queue view for the searches
  addr_t [depth-1:0]          entry_addr;
  logic [depth-1:0]           store_mask;
  logic [depth-1:0]           waiting_store_mask;
  logic [$clog2(depth)-1:0]   oldest;
  logic [$clog2(depth)-1:0]   fwd_index;
  logic [$clog2(depth)-1:0]   merge_index;

  mshr_alloc_select alloc0 (
    .miss_valid  (miss_valid),
    .slot_lane   (slot_lane),
    .alloc_count (alloc_count)
  );

  mshr_queue #(
    .depth (depth)
  ) queue0 (
    .clock              (clock),
    .reset              (reset),
    .miss_valid         (miss_valid),
    .miss_addr          (miss_addr),
    .miss_cmd           (miss_cmd),
    .miss_data          (miss_data),
    .miss_ready         (miss_ready),
    .slot_lane          (slot_lane),
    .alloc_count        (alloc_count),
    .mem_cmd            (mem_cmd),
    .mem_addr           (mem_addr),
    .mem_data           (mem_data),
    .mem_response       (mem_response),
    .mem_tag            (mem_tag),
    .mem_rdata          (mem_rdata),
    .fill_valid         (fill_valid),
    .fill_addr          (fill_addr),
    .fill_data          (fill_data),
    .fill_ready         (fill_ready),
    .entry_addr         (entry_addr),
    .store_mask         (store_mask),
    .waiting_store_mask (waiting_store_mask),
    .oldest             (oldest),
    .fwd_index          (fwd_index),
    .merge_hit_int      (merge_hit),
    .merge_index        (merge_index),
    .merge_valid        (merge_valid),
    .merge_data         (merge_data),
    .lookup_data        (lookup_data)
  );

  // load search over all pending stores
  mshr_lookup #(
    .depth (depth)
  ) fwd_lookup0 (
    .key        (lookup_addr),
    .entry_addr (entry_addr),
    .eligible   (store_mask),
    .oldest     (oldest),
    .hit        (lookup_hit),
    .index      (fwd_index)
  );

  // store merge over stores not yet sent
  mshr_lookup #(
    .depth (depth)
  ) merge_lookup0 (
    .key        (merge_addr),
    .entry_addr (entry_addr),
    .eligible   (waiting_store_mask),
    .oldest     (oldest),
    .hit        (merge_hit),
    .index      (merge_index)
  );

endmodule

//--- source/mshr_alloc_select.sv
module mshr_alloc_select (
  input  logic [mshr_pkg::miss_lanes-1:0]      miss_valid,
  output logic [mshr_pkg::miss_lanes-1:0][1:0] slot_lane,
  output logic [1:0]                           alloc_count
);
  import mshr_pkg::*;

  // lanes not yet claimed by an earlier stage
  logic [miss_lanes-1:0] remaining [miss_lanes];
  // one-hot pick of each stage
  logic [miss_lanes-1:0] pick      [miss_lanes];

  function automatic logic [1:0] encode_lane(input logic [miss_lanes-1:0] onehot);
    logic [1:0] lane;
    lane = 2'd0;
    for (int i = 0; i < miss_lanes; i++) begin
      if (onehot[i]) begin
        lane = 2'(i);
      end
    end
    return lane;
  endfunction

  // slot k takes the k-th valid lane, lowest lane first
  always_comb begin
    remaining[0] = miss_valid;
    for (int s = 0; s < miss_lanes; s++) begin
      // isolate lowest set bit
      pick[s] = remaining[s] & (~remaining[s] + 1'b1);
      slot_lane[s] = encode_lane(pick[s]);
      if (s + 1 < miss_lanes) begin
        remaining[s+1] = remaining[s] & ~pick[s];
      end
    end
  end

  // number of lanes to allocate
  always_comb begin
    alloc_count = 2'd0;
    for (int l = 0; l < miss_lanes; l++) begin
      alloc_count = alloc_count + 2'(miss_valid[l]);
    end
  end

endmodule

//--- source/mshr_lookup.sv
module mshr_lookup #(
  parameter int depth = 8
) (
  input  mshr_pkg::addr_t             key,
  input  mshr_pkg::addr_t [depth-1:0] entry_addr,
  input  logic [depth-1:0]            eligible,
  input  logic [$clog2(depth)-1:0]    oldest,
  output logic                        hit,
  output logic [$clog2(depth)-1:0]    index
);

  localparam int ptr_w = $clog2(depth);

  logic [depth-1:0] match;
  // bit 0 is the oldest entry, higher bits are younger
  logic [depth-1:0] age_match;
  logic [ptr_w-1:0] young_offset;

  always_comb begin
    for (int i = 0; i < depth; i++) begin
      match[i] = eligible[i] && (entry_addr[i] == key);
    end
  end

  // rotate into age order
  always_comb begin
    for (int i = 0; i < depth; i++) begin
      age_match[i] = match[oldest + ptr_w'(i)];
    end
  end

  // youngest match wins, so the last one seen is kept
  always_comb begin
    hit = 1'b0;
    young_offset = '0;
    for (int i = 0; i < depth; i++) begin
      if (age_match[i]) begin
        hit = 1'b1;
        young_offset = ptr_w'(i);
      end
    end
  end

  // back to a physical slot
  assign index = oldest + young_offset;

endmodule

//--- source/mshr_pkg.sv
package mshr_pkg;

  // miss request lanes offered per cycle
  localparam int miss_lanes = 3;

  // line address, whole lines only
  typedef logic [31:0] addr_t;

  // one cache line
  typedef logic [63:0] data_t;

  // memory transaction tag, zero means no transaction
  typedef logic [3:0] mem_tag_t;

  // memory bus command
  typedef enum logic [1:0] {
    bus_none  = 2'd0,
    bus_load  = 2'd1,
    bus_store = 2'd2
  } mem_cmd_t;

  // entry lifetime
  // waiting until memory accepts, in_progress until load data returns
  typedef enum logic [1:0] {
    waiting     = 2'd0,
    in_progress = 2'd1,
    done        = 2'd2
  } entry_state_t;

endpackage

//--- source/mshr_queue.sv
module mshr_queue #(
  parameter int depth = 8
) (
  input  logic                                          clock,
  input  logic                                          reset,
  input  logic [mshr_pkg::miss_lanes-1:0]               miss_valid,
  input  mshr_pkg::addr_t [mshr_pkg::miss_lanes-1:0]    miss_addr,
  input  mshr_pkg::mem_cmd_t [mshr_pkg::miss_lanes-1:0] miss_cmd,
  input  mshr_pkg::data_t [mshr_pkg::miss_lanes-1:0]    miss_data,
  output logic                                          miss_ready,
  input  logic [mshr_pkg::miss_lanes-1:0][1:0]          slot_lane,
  input  logic [1:0]                                    alloc_count,
  output mshr_pkg::mem_cmd_t                            mem_cmd,
  output mshr_pkg::addr_t                               mem_addr,
  output mshr_pkg::data_t                               mem_data,
  input  mshr_pkg::mem_tag_t                            mem_response,
  input  mshr_pkg::mem_tag_t                            mem_tag,
  input  mshr_pkg::data_t                               mem_rdata,
  output logic                                          fill_valid,
  output mshr_pkg::addr_t                               fill_addr,
  output mshr_pkg::data_t                               fill_data,
  input  logic                                          fill_ready,
  output mshr_pkg::addr_t [depth-1:0]                   entry_addr,
  output logic [depth-1:0]                              store_mask,
  output logic [depth-1:0]                              waiting_store_mask,
  output logic [$clog2(depth)-1:0]                      oldest,
  input  logic [$clog2(depth)-1:0]                      fwd_index,
  input  logic                                          merge_hit_int,
  input  logic [$clog2(depth)-1:0]                      merge_index,
  input  logic                                          merge_valid,
  input  mshr_pkg::data_t                               merge_data,
  output mshr_pkg::data_t                               lookup_data
);
  import mshr_pkg::*;

  localparam int ptr_w = $clog2(depth);

  // entry storage
  logic [depth-1:0]  ent_valid;
  mem_cmd_t          ent_cmd   [depth];
  addr_t [depth-1:0] ent_addr;
  data_t             ent_data  [depth];
  entry_state_t      ent_state [depth];
  mem_tag_t          ent_tag   [depth];

  logic [ptr_w-1:0] tail_ptr;
  logic [ptr_w-1:0] issue_ptr;
  logic [ptr_w-1:0] retire_ptr;

  logic [ptr_w:0]          used_count;
  logic                    alloc_en;
  logic [miss_lanes-1:0]   slot_used;
  logic [ptr_w-1:0]        slot_ptr [miss_lanes];
  logic                    issue_pending;
  logic                    issue_accept;
  logic [depth-1:0]        tag_hit;
  logic                    retire_done;
  logic                    retire_go;

  // occupancy
  always_comb begin
    used_count = '0;
    for (int i = 0; i < depth; i++) begin
      used_count = used_count + (ptr_w + 1)'(ent_valid[i]);
    end
  end

  // room for a full group of lanes
  assign miss_ready = (int'(used_count) + miss_lanes) <= depth;
  assign alloc_en = miss_ready && (|miss_valid);

  // consecutive slots from the tail
  always_comb begin
    for (int k = 0; k < miss_lanes; k++) begin
      slot_used[k] = k < int'(alloc_count);
      slot_ptr[k] = tail_ptr + ptr_w'(k);
    end
  end

  // memory request from the oldest entry not yet sent
  assign issue_pending = ent_valid[issue_ptr] && (ent_state[issue_ptr] == waiting);
  assign mem_cmd = issue_pending ? ent_cmd[issue_ptr] : bus_none;
  assign mem_addr = ent_addr[issue_ptr];
  assign mem_data = ent_data[issue_ptr];
  assign issue_accept = issue_pending && (mem_response != '0);

  // returning load data, tags are unique while outstanding
  always_comb begin
    for (int i = 0; i < depth; i++) begin
      tag_hit[i] = ent_valid[i] && (ent_state[i] == in_progress)
                   && (mem_tag != '0) && (ent_tag[i] == mem_tag);
    end
  end

  // retire strictly in allocation order
  assign retire_done = ent_valid[retire_ptr] && (ent_state[retire_ptr] == done);
  assign fill_valid = retire_done && (ent_cmd[retire_ptr] == bus_load);
  assign fill_addr = ent_addr[retire_ptr];
  assign fill_data = ent_data[retire_ptr];
  // done stores leave without a fill
  assign retire_go = fill_valid ? fill_ready : retire_done;

  // search masks for the two lookups
  // a store handed to memory this cycle can no longer take merged data
  always_comb begin
    for (int i = 0; i < depth; i++) begin
      store_mask[i] = ent_valid[i] && (ent_cmd[i] == bus_store);
      waiting_store_mask[i] = store_mask[i] && (ent_state[i] == waiting)
                              && !(issue_accept && (issue_ptr == ptr_w'(i)));
    end
  end

  assign entry_addr = ent_addr;
  assign oldest = retire_ptr;
  assign lookup_data = ent_data[fwd_index];

  // control state
  always_ff @(posedge clock) begin
    if (reset) begin
      ent_valid <= '0;
      for (int i = 0; i < depth; i++) begin
        ent_state[i] <= waiting;
      end
      tail_ptr <= '0;
      issue_ptr <= '0;
      retire_ptr <= '0;
    end else begin
      if (alloc_en) begin
        for (int k = 0; k < miss_lanes; k++) begin
          if (slot_used[k]) begin
            ent_valid[slot_ptr[k]] <= 1'b1;
            ent_state[slot_ptr[k]] <= waiting;
          end
        end
        tail_ptr <= tail_ptr + ptr_w'(alloc_count);
      end
      if (issue_accept) begin
        // stores need no response data
        ent_state[issue_ptr] <= (ent_cmd[issue_ptr] == bus_store) ? done : in_progress;
        issue_ptr <= issue_ptr + 1'b1;
      end
      for (int i = 0; i < depth; i++) begin
        if (tag_hit[i]) begin
          ent_state[i] <= done;
        end
      end
      if (retire_go) begin
        ent_valid[retire_ptr] <= 1'b0;
        retire_ptr <= retire_ptr + 1'b1;
      end
    end
  end

  // entry payload
  always_ff @(posedge clock) begin
    if (alloc_en) begin
      for (int k = 0; k < miss_lanes; k++) begin
        if (slot_used[k]) begin
          ent_cmd[slot_ptr[k]] <= miss_cmd[slot_lane[k]];
          ent_addr[slot_ptr[k]] <= miss_addr[slot_lane[k]];
          ent_data[slot_ptr[k]] <= miss_data[slot_lane[k]];
          ent_tag[slot_ptr[k]] <= '0;
        end
      end
    end
    if (issue_accept) begin
      ent_tag[issue_ptr] <= mem_response;
    end
    for (int i = 0; i < depth; i++) begin
      if (tag_hit[i]) begin
        ent_data[i] <= mem_rdata;
      end
    end
    // merge only ever targets a waiting store, never a tagged load
    if (merge_valid && merge_hit_int) begin
      ent_data[merge_index] <= merge_data;
    end
  end

endmodule
